// ==== tb/soc_cases.txt ====
# Columns: op addr value expect, fields in hex
# W write/R read (value=data, expect=pslverr), T status, N nrst {ddr,dbg,sys}, G gpio out dir
# C calib level, D dmireset cycles, P pins, S wait sys_nrst, L random gpio loop count
T 000 00 0
N 000 0 0
R 200 0 1
W 2f0 1234 1
C 000 1 0
S 000 0 0
N 000 7 0
T 000 2f 0
R 004 0 0
R 0f0 0 0
W 100 abc 0
W 104 fff555 0
G 000 555 abc
R 100 abc 0
R 104 555 0
L 000 8 0
P 000 a5c 0
R 108 a5c 0
W 108 123 0
R 108 a5c 0
W 100 fff 0
W 104 0f0 0
G 000 0f0 fff
W 004 1 0
N 000 6 0
G 000 0 0
T 000 37 0
S 000 0 0
T 000 2f 0
R 104 0 0
W 100 00f 0
W 104 00a 0
G 000 00a 00f
D 000 3 0
N 000 6 0
G 000 0 0
T 000 37 0
S 000 0 0
R 100 0 0
R 104 0 0

// ==== vlog.f ====
+incdir+include
rtl/soc_pkg.sv
rtl/apb_decoder.sv
rtl/apb_prci.sv
rtl/apb_gpio.sv
rtl/soc_periph_top.sv
tb/soc_periph_properties.sv
tb/tb_soc_periph.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project root"
  exit 1
fi

verilator --binary --timing --assert -f vlog.f --top-module tb_soc_periph \
  --Mdir obj_dir -o tb_soc_periph
if [ $? -ne 0 ]; then
  echo "Verilator build error"
  exit 1
fi

./obj_dir/tb_soc_periph
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi
exit 0

// ==== tb/tb_soc_periph.sv ====
// Testbench for the peripheral and reset subsystem
// Reads operations and expected values from tb/soc_cases.txt
// APB driver, pin and reset stimulus, typed checks and a watchdog

`timescale 1ns/1ps

`include "soc_macros.svh"

module tb_soc_periph;

  localparam int CLK_PERIOD = 40;
  localparam int DRV_DLY    = 2;
  localparam int RST_CYCLES = 10;
  // Access cycles allowed before a missing pready stops the run
  localparam int MAX_WAITS  = 8;
  localparam logic [`SOC_APB_ADDR_W-1:0] STAT_ADDR =
    `SOC_PRCI_BASE | `SOC_APB_ADDR_W'(`PRCI_REG_STATUS);
  localparam logic [`SOC_APB_ADDR_W-1:0] DIR_ADDR  =
    `SOC_GPIO_BASE | `SOC_APB_ADDR_W'(`GPIO_REG_DIR);
  localparam logic [`SOC_APB_ADDR_W-1:0] OUT_ADDR  =
    `SOC_GPIO_BASE | `SOC_APB_ADDR_W'(`GPIO_REG_OUT);

  logic                   clk;
  logic                   rst;
  logic                   dmireset;
  logic                   calib_done;
  soc_pkg::apb_in_t       apb_req;
  soc_pkg::apb_out_t      apb_rsp;
  logic [`SOC_GPIO_W-1:0] gpio_in;
  logic [`SOC_GPIO_W-1:0] gpio_out;
  logic [`SOC_GPIO_W-1:0] gpio_dir;
  logic                   ddr_nrst;
  logic                   dbg_nrst;
  logic                   sys_nrst;

  // Case table with one entry per data line
  logic [7:0]  case_op[$];
  logic [31:0] case_a[$];
  logic [31:0] case_b[$];
  logic [31:0] case_c[$];
  int          n_cases = 0;
  bit          cases_loaded = 1'b0;
  int          err_cnt = 0;
  logic [31:0] rng_state = 32'd41883;

  soc_periph_top i_soc_periph_top (
    .i_clk (clk), .i_rst (rst), .i_dmireset (dmireset), .i_ddr_calib_done (calib_done),
    .i_apb (apb_req), .o_apb (apb_rsp), .i_gpio (gpio_in), .o_gpio (gpio_out),
    .o_gpio_dir (gpio_dir), .o_ddr_nrst (ddr_nrst), .o_dbg_nrst (dbg_nrst),
    .o_sys_nrst (sys_nrst)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  // 32-bit xorshift step
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_apb(input soc_pkg::apb_out_t got, input soc_pkg::apb_out_t exp,
                           input bit with_data, input string what);
    if (got.pready !== exp.pready || got.pslverr !== exp.pslverr ||
        (with_data && got.prdata !== exp.prdata)) begin
      err_cnt++;
      $display("FAILED at %0t ns: %s ready %b err %b data %h, expected %b %b %h", $time,
               what, got.pready, got.pslverr, got.prdata, exp.pready, exp.pslverr, exp.prdata);
      abort_run();
    end
  endtask

  task automatic check_status(input soc_pkg::prci_status_t got,
                              input soc_pkg::prci_status_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED at %0t ns: STATUS %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_gpio(input logic [`SOC_GPIO_W-1:0] got_out, got_dir,
                            input logic [`SOC_GPIO_W-1:0] exp_out, exp_dir);
    if (got_out !== exp_out || got_dir !== exp_dir) begin
      err_cnt++;
      $display("FAILED at %0t ns: gpio out %h dir %h, expected %h %h", $time,
               got_out, got_dir, exp_out, exp_dir);
      abort_run();
    end
  endtask

  // Reset levels as {ddr, dbg, sys}
  task automatic check_nrst(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED at %0t ns: nrst levels %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  // One setup cycle then access cycles until pready at the falling edge
  task automatic apb_xfer(input logic wr, input logic [`SOC_APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output soc_pkg::apb_out_t rsp);
    int waits;
    waits = 0;
    @(posedge clk);
    #DRV_DLY;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #DRV_DLY;
    apb_req.penable = 1'b1;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1) begin
      if (waits == MAX_WAITS) begin
        $display("No pready from the DUT for address %h at %0t ns", addr, $time);
        abort_run();
      end
      waits++;
      @(negedge clk);
    end
    rsp = apb_rsp;
    @(posedge clk);
    #DRV_DLY;
    apb_req = '0;
  endtask

  task automatic apb_access(input logic wr, input logic [`SOC_APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input soc_pkg::apb_out_t exp,
                            input bit with_data);
    soc_pkg::apb_out_t rsp;
    apb_xfer(wr, addr, wdata, rsp);
    check_apb(rsp, exp, with_data, $sformatf("%s at %h", wr ? "write" : "read", addr));
  endtask

  task automatic read_status(input soc_pkg::prci_status_t exp_st);
    soc_pkg::apb_out_t rsp;
    soc_pkg::apb_out_t exp;
    soc_pkg::prci_status_t got;
    exp.pready  = 1'b1;
    exp.pslverr = 1'b0;
    // Register is the status word zero-extended
    exp.prdata  = 32'(exp_st);
    apb_xfer(1'b0, STAT_ADDR, 32'h0, rsp);
    got = rsp.prdata[$bits(soc_pkg::prci_status_t)-1:0];
    check_status(got, exp_st);
    check_apb(rsp, exp, 1'b1, "STATUS read");
  endtask

  // Random DIR and OUT values checked on the pins and by readback
  task automatic gpio_random_loop(input int n);
    logic [31:0] dir_w;
    logic [31:0] out_w;
    soc_pkg::apb_out_t exp;
    int i;
    exp.pready  = 1'b1;
    exp.pslverr = 1'b0;
    for (i = 0; i < n; i++) begin
      rng_state = next_rand(rng_state);
      dir_w = rng_state;
      rng_state = next_rand(rng_state);
      out_w = rng_state;
      exp.prdata = 32'h0;
      apb_access(1'b1, DIR_ADDR, dir_w, exp, 1'b0);
      apb_access(1'b1, OUT_ADDR, out_w, exp, 1'b0);
      @(negedge clk);
      check_gpio(gpio_out, gpio_dir, out_w[`SOC_GPIO_W-1:0], dir_w[`SOC_GPIO_W-1:0]);
      // Upper pwdata bits are dropped
      exp.prdata = 32'(dir_w[`SOC_GPIO_W-1:0]);
      apb_access(1'b0, DIR_ADDR, 32'h0, exp, 1'b1);
      exp.prdata = 32'(out_w[`SOC_GPIO_W-1:0]);
      apb_access(1'b0, OUT_ADDR, 32'h0, exp, 1'b1);
    end
  endtask

  task automatic load_cases();
    int fd;
    int cnt;
    string line;
    logic [7:0] op;
    logic [31:0] a, b, c;
    fd = $fopen("tb/soc_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file tb/soc_cases.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      // Comment and blank lines
      if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n" ||
          line.getc(0) == " " || line.getc(0) == "\r") begin
        continue;
      end
      cnt = $sscanf(line, "%c %h %h %h", op, a, b, c);
      if (cnt != 4) begin
        $display("Malformed line in the case file: %s", line);
        abort_run();
      end
      case_op.push_back(op);
      case_a.push_back(a);
      case_b.push_back(b);
      case_c.push_back(c);
    end
    $fclose(fd);
    n_cases = case_op.size();
  endtask

  task automatic run_case(input logic [7:0] op, input logic [31:0] a, b, c);
    soc_pkg::apb_out_t exp;
    exp.pready  = 1'b1;
    exp.pslverr = c[0];
    exp.prdata  = b;
    case (op)
      "W": apb_access(1'b1, a[`SOC_APB_ADDR_W-1:0], b, exp, 1'b0);
      "R": apb_access(1'b0, a[`SOC_APB_ADDR_W-1:0], 32'h0, exp, 1'b1);
      "T": read_status(b[$bits(soc_pkg::prci_status_t)-1:0]);
      "N": begin
        @(negedge clk);
        check_nrst({ddr_nrst, dbg_nrst, sys_nrst}, b[2:0]);
      end
      // Outputs follow a write one cycle later
      "G": begin
        @(posedge clk);
        @(negedge clk);
        check_gpio(gpio_out, gpio_dir, b[`SOC_GPIO_W-1:0], c[`SOC_GPIO_W-1:0]);
      end
      "C": begin
        @(posedge clk);
        #DRV_DLY;
        calib_done = b[0];
      end
      "D": begin
        @(posedge clk);
        #DRV_DLY;
        dmireset = 1'b1;
        repeat (int'(b)) @(posedge clk);
        #DRV_DLY;
        dmireset = 1'b0;
      end
      // Two synchronizer stages before IN shows the pins
      "P": begin
        @(posedge clk);
        #DRV_DLY;
        gpio_in = b[`SOC_GPIO_W-1:0];
        repeat (2) @(posedge clk);
      end
      "S": begin
        @(negedge clk);
        while (sys_nrst !== 1'b1) @(negedge clk);
      end
      "L": gpio_random_loop(int'(b));
      default: begin
        $display("Unknown operation code %h in the case file", op);
        abort_run();
      end
    endcase
  endtask

  initial begin : main
    int idx;
    clk        = 1'b0;
    rst        = 1'b1;
    dmireset   = 1'b0;
    calib_done = 1'b0;
    apb_req    = '0;
    gpio_in    = '0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #DRV_DLY;
    rst = 1'b0;
    for (idx = 0; idx < n_cases; idx++) begin
      run_case(case_op[idx], case_a[idx], case_b[idx], case_c[idx]);
    end
    if (err_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run();
    end
  end

  // Budget of 64 cycles per case plus the reset phase
  initial begin : watchdog
    wait (cases_loaded);
    #((n_cases * 64 + RST_CYCLES) * CLK_PERIOD);
    $display("The run timed out after %0t ns with %0d cases", $time, n_cases);
    abort_run();
  end

endmodule

// ==== tb/soc_periph_properties.sv ====
// Bound checks on the subsystem top level
// APB response timing, reset ordering, GPIO state while held

`timescale 1ns/1ps

`include "soc_macros.svh"

module soc_periph_properties (
  input logic                   i_clk,
  input logic                   i_rst,
  input soc_pkg::apb_in_t       i_apb,
  input soc_pkg::apb_out_t      i_apb_rsp,
  input logic                   i_ddr_nrst,
  input logic                   i_sys_nrst,
  input logic [`SOC_GPIO_W-1:0] i_gpio_dir
);

  // Slave windows of the address map
  localparam logic [`SOC_APB_ADDR_W-1:0] PRCI_BASE = `SOC_PRCI_BASE;
  localparam logic [`SOC_APB_ADDR_W-1:0] GPIO_BASE = `SOC_GPIO_BASE;

  logic [`SOC_APB_ADDR_W-1:`SOC_REG_OFFS_W] w_sel;
  logic                                     w_unmapped;

  // Host address outside both windows
  assign w_sel      = i_apb.paddr[`SOC_APB_ADDR_W-1:`SOC_REG_OFFS_W];
  assign w_unmapped = (w_sel != PRCI_BASE[`SOC_APB_ADDR_W-1:`SOC_REG_OFFS_W]) &&
                      (w_sel != GPIO_BASE[`SOC_APB_ADDR_W-1:`SOC_REG_OFFS_W]);

  // pready only in the access cycle
  assert property (@(posedge i_clk) disable iff (i_rst)
    i_apb_rsp.pready |-> (i_apb.psel && i_apb.penable))
    else $error("pready outside an access cycle");

  // Error only with pready and only for an unmapped address
  assert property (@(posedge i_clk) disable iff (i_rst)
    i_apb_rsp.pslverr |-> (i_apb_rsp.pready && w_unmapped))
    else $error("pslverr without pready or on a mapped address");

  // System domain never runs ahead of DDR
  assert property (@(posedge i_clk) disable iff (i_rst)
    i_sys_nrst |-> i_ddr_nrst)
    else $error("system reset released while DDR held");

  // GPIO clears one cycle after the system domain drops
  assert property (@(posedge i_clk) disable iff (i_rst)
    (!i_sys_nrst && !$past(i_sys_nrst)) |-> (i_gpio_dir == '0))
    else $error("GPIO direction nonzero while system held");

endmodule

bind soc_periph_top soc_periph_properties i_soc_periph_properties (
  .i_clk (i_clk), .i_rst (i_rst), .i_apb (i_apb), .i_apb_rsp (o_apb),
  .i_ddr_nrst (o_ddr_nrst), .i_sys_nrst (o_sys_nrst), .i_gpio_dir (o_gpio_dir)
);

// ==== rtl/soc_periph_top.sv ====
// Peripheral and reset subsystem top level
// APB decoder, reset controller and GPIO block

`timescale 1ns/1ps

`include "soc_macros.svh"

module soc_periph_top (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_dmireset,
  input  logic                   i_ddr_calib_done,
  input  soc_pkg::apb_in_t       i_apb,
  output soc_pkg::apb_out_t      o_apb,
  input  logic [`SOC_GPIO_W-1:0] i_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio_dir,
  output logic                   o_ddr_nrst,
  output logic                   o_dbg_nrst,
  output logic                   o_sys_nrst
);

  // Slave-side APB
  soc_pkg::apb_in_t  w_prci_apbi;
  soc_pkg::apb_out_t w_prci_apbo;
  soc_pkg::apb_in_t  w_gpio_apbi;
  soc_pkg::apb_out_t w_gpio_apbo;

  // System reset also feeds GPIO
  logic w_sys_nrst;

  apb_decoder i_apb_decoder (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_apb      (i_apb),
    .o_apb      (o_apb),
    .o_prci_apb (w_prci_apbi),
    .i_prci_apb (w_prci_apbo),
    .o_gpio_apb (w_gpio_apbi),
    .i_gpio_apb (w_gpio_apbo)
  );

  // Reset control, power-on reset only
  apb_prci i_apb_prci (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_dmireset       (i_dmireset),
    .i_ddr_calib_done (i_ddr_calib_done),
    .i_apb            (w_prci_apbi),
    .o_apb            (w_prci_apbo),
    .o_ddr_nrst       (o_ddr_nrst),
    .o_dbg_nrst       (o_dbg_nrst),
    .o_sys_nrst       (w_sys_nrst)
  );

  apb_gpio i_apb_gpio (
    .i_clk      (i_clk),
    .i_sys_nrst (w_sys_nrst),
    .i_apb      (w_gpio_apbi),
    .o_apb      (w_gpio_apbo),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir)
  );

  assign o_sys_nrst = w_sys_nrst;

endmodule

// ==== rtl/apb_gpio.sv ====
// GPIO block with direction and output registers
// Two-flop synchronizer on the input pins
// APB slave, held in reset by the system domain

`timescale 1ns/1ps

`include "soc_macros.svh"

module apb_gpio (
  input  logic                   i_clk,
  input  logic                   i_sys_nrst,
  input  soc_pkg::apb_in_t       i_apb,
  output soc_pkg::apb_out_t      o_apb,
  input  logic [`SOC_GPIO_W-1:0] i_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio_dir
);

  logic [`SOC_GPIO_W-1:0]     r_dir;
  logic [`SOC_GPIO_W-1:0]     r_out;
  logic [`SOC_GPIO_W-1:0]     r_sync1;
  logic [`SOC_GPIO_W-1:0]     r_sync2;
  logic                       r_ready;
  logic [31:0]                r_rdata;

  logic                       w_setup;
  logic                       w_wr;
  logic [`SOC_REG_OFFS_W-1:0] w_offs;

  assign w_setup = i_apb.psel & ~i_apb.penable;
  // Writes land on the access edge
  assign w_wr    = i_apb.psel & i_apb.penable & i_apb.pwrite;
  assign w_offs  = i_apb.paddr[`SOC_REG_OFFS_W-1:0];

  // Pin inputs, two stages before software sees them
  always_ff @(posedge i_clk) begin
    r_sync1 <= i_gpio;
    r_sync2 <= r_sync1;
  end

  // DIR and OUT, cleared while the system domain is held
  always_ff @(posedge i_clk) begin
    if (!i_sys_nrst) begin
      r_dir <= '0;
      r_out <= '0;
    end else if (w_wr) begin
      case (w_offs)
        `GPIO_REG_DIR: r_dir <= i_apb.pwdata[`SOC_GPIO_W-1:0];
        `GPIO_REG_OUT: r_out <= i_apb.pwdata[`SOC_GPIO_W-1:0];
        // IN is read-only
        default: ;
      endcase
    end
  end

  // No wait states
  always_ff @(posedge i_clk) begin
    if (!i_sys_nrst) begin
      r_ready <= 1'b0;
    end else begin
      r_ready <= w_setup;
    end
  end

  // Register readback, zero-extended
  always_ff @(posedge i_clk) begin
    if (w_setup) begin
      case (w_offs)
        `GPIO_REG_DIR: r_rdata <= 32'(r_dir);
        `GPIO_REG_OUT: r_rdata <= 32'(r_out);
        `GPIO_REG_IN:  r_rdata <= 32'(r_sync2);
        default:       r_rdata <= 32'h0;
      endcase
    end
  end

  assign o_apb.pready  = r_ready;
  assign o_apb.pslverr = 1'b0;
  assign o_apb.prdata  = r_rdata;

  assign o_gpio     = r_out;
  assign o_gpio_dir = r_dir;

endmodule

// ==== rtl/apb_prci.sv ====
// Reset sequencer for the DDR, debug and system domains
// Ordered release after power-on, system re-hold on soft or debug reset
// APB slave with STATUS and SOFTRST registers

`timescale 1ns/1ps

`include "soc_macros.svh"

module apb_prci (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_dmireset,
  input  logic              i_ddr_calib_done,
  input  soc_pkg::apb_in_t  i_apb,
  output soc_pkg::apb_out_t o_apb,
  output logic              o_ddr_nrst,
  output logic              o_dbg_nrst,
  output logic              o_sys_nrst
);

  // Hold counter runs 0 .. PRCI_RST_HOLD-1
  localparam int CNT_W = $clog2(`PRCI_RST_HOLD);

  soc_pkg::prci_state_e r_state;
  logic [CNT_W-1:0]     r_cnt;
  logic                 r_ddr_nrst;
  logic                 r_dbg_nrst;
  logic                 r_sys_nrst;
  logic                 r_ready;
  logic [31:0]          r_rdata;

  logic                 w_setup;
  logic                 w_access;
  logic [`SOC_REG_OFFS_W-1:0] w_offs;
  logic                 w_softrst_wr;
  logic                 w_sys_req;
  logic                 w_cnt_done;
  soc_pkg::prci_status_t w_status;

  // APB phase decode
  assign w_setup  = i_apb.psel & ~i_apb.penable;
  assign w_access = i_apb.psel & i_apb.penable;
  assign w_offs   = i_apb.paddr[`SOC_REG_OFFS_W-1:0];

  // Soft reset takes effect on the access edge
  assign w_softrst_wr = w_access & i_apb.pwrite & i_apb.pwdata[0] &
                        (w_offs == `PRCI_REG_SOFTRST);

  // Either source puts the system domain back into reset
  assign w_sys_req  = w_softrst_wr | i_dmireset;
  assign w_cnt_done = (r_cnt == CNT_W'(`PRCI_RST_HOLD - 1));

  // Reset sequencer
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_state    <= soc_pkg::PRCI_PWR_HOLD;
      r_cnt      <= '0;
      r_ddr_nrst <= 1'b0;
      r_dbg_nrst <= 1'b0;
      r_sys_nrst <= 1'b0;
    end else begin
      case (r_state)
        soc_pkg::PRCI_PWR_HOLD: begin
          // Power-on hold, then let DDR go
          if (w_cnt_done) begin
            r_state    <= soc_pkg::PRCI_WAIT_CALIB;
            r_ddr_nrst <= 1'b1;
            r_cnt      <= '0;
          end else begin
            r_cnt <= r_cnt + 1'b1;
          end
        end
        soc_pkg::PRCI_WAIT_CALIB: begin
          // Debug and system come up together once DDR is calibrated
          if (i_ddr_calib_done) begin
            r_state    <= soc_pkg::PRCI_RUN;
            r_dbg_nrst <= 1'b1;
            r_sys_nrst <= 1'b1;
          end
        end
        soc_pkg::PRCI_RUN: begin
          if (w_sys_req) begin
            r_state    <= soc_pkg::PRCI_SYS_HOLD;
            r_sys_nrst <= 1'b0;
            r_cnt      <= '0;
          end
        end
        soc_pkg::PRCI_SYS_HOLD: begin
          // Hold restarts while dmireset stays high or on a new soft reset
          if (w_sys_req) begin
            r_cnt <= '0;
          end else if (w_cnt_done) begin
            r_state    <= soc_pkg::PRCI_RUN;
            r_sys_nrst <= 1'b1;
          end else begin
            r_cnt <= r_cnt + 1'b1;
          end
        end
        default: r_state <= soc_pkg::PRCI_PWR_HOLD;
      endcase
    end
  end

  // Status word as seen on a STATUS read
  assign w_status.state          = r_state;
  assign w_status.sys_nrst       = r_sys_nrst;
  assign w_status.dbg_nrst       = r_dbg_nrst;
  assign w_status.ddr_nrst       = r_ddr_nrst;
  assign w_status.ddr_calib_done = i_ddr_calib_done;

  // Access-phase ready, armed on the setup edge
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ready <= 1'b0;
    end else begin
      r_ready <= w_setup;
    end
  end

  // Read data captured at setup; SOFTRST and holes read as zero
  always_ff @(posedge i_clk) begin
    if (w_setup) begin
      r_rdata <= (w_offs == `PRCI_REG_STATUS) ? 32'(w_status) : 32'h0;
    end
  end

  assign o_apb.pready  = r_ready;
  assign o_apb.pslverr = 1'b0;
  assign o_apb.prdata  = r_rdata;

  assign o_ddr_nrst = r_ddr_nrst;
  assign o_dbg_nrst = r_dbg_nrst;
  assign o_sys_nrst = r_sys_nrst;

endmodule

// ==== rtl/apb_decoder.sv ====
// APB address decoder for the peripheral subsystem
// Routes the host port to PRCI or GPIO by address bits 11:8
// Error response for unmapped addresses

`timescale 1ns/1ps

`include "soc_macros.svh"

module apb_decoder (
  input  logic              i_clk,
  input  logic              i_rst,
  input  soc_pkg::apb_in_t  i_apb,
  output soc_pkg::apb_out_t o_apb,
  output soc_pkg::apb_in_t  o_prci_apb,
  input  soc_pkg::apb_out_t i_prci_apb,
  output soc_pkg::apb_in_t  o_gpio_apb,
  input  soc_pkg::apb_out_t i_gpio_apb
);

  localparam logic [`SOC_APB_ADDR_W-1:0] PRCI_BASE = `SOC_PRCI_BASE;
  localparam logic [`SOC_APB_ADDR_W-1:0] GPIO_BASE = `SOC_GPIO_BASE;
  // Top address bits pick the slave
  localparam int SEL_LSB = `SOC_REG_OFFS_W;

  logic w_hit_prci;
  logic w_hit_gpio;
  logic r_err;

  assign w_hit_prci =
    (i_apb.paddr[`SOC_APB_ADDR_W-1:SEL_LSB] == PRCI_BASE[`SOC_APB_ADDR_W-1:SEL_LSB]);
  assign w_hit_gpio =
    (i_apb.paddr[`SOC_APB_ADDR_W-1:SEL_LSB] == GPIO_BASE[`SOC_APB_ADDR_W-1:SEL_LSB]);

  // Same request to both slaves, psel only where it hits
  always_comb begin
    o_prci_apb      = i_apb;
    o_prci_apb.psel = i_apb.psel & w_hit_prci;
    o_gpio_apb      = i_apb;
    o_gpio_apb.psel = i_apb.psel & w_hit_gpio;
  end

  // Unmapped setup cycle arms the error response
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_err <= 1'b0;
    end else begin
      r_err <= i_apb.psel & ~i_apb.penable & ~w_hit_prci & ~w_hit_gpio;
    end
  end

  // Response mux, address is stable through the access cycle
  always_comb begin
    o_apb.pready  = r_err;
    o_apb.pslverr = r_err;
    o_apb.prdata  = 32'h0;
    if (w_hit_prci) begin
      o_apb = i_prci_apb;
    end else if (w_hit_gpio) begin
      o_apb = i_gpio_apb;
    end
  end

endmodule

// ==== rtl/soc_pkg.sv ====
// Shared types of the peripheral subsystem
// APB request and response structs
// PRCI state encoding and status word layout

`include "soc_macros.svh"

package soc_pkg;

  // Host to slave request
  typedef struct packed {
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [`SOC_APB_ADDR_W-1:0]   paddr;
    logic [31:0]                  pwdata;
  } apb_in_t;

  // Slave to host response
  // pslverr and prdata only meaningful with pready
  typedef struct packed {
    logic         pready;
    logic         pslverr;
    logic [31:0]  prdata;
  } apb_out_t;

  // Reset sequencer states
  typedef enum logic [1:0] {
    // DDR, debug and system all held after power-on
    PRCI_PWR_HOLD   = 2'd0,
    // DDR released, waiting on calibration
    PRCI_WAIT_CALIB = 2'd1,
    // Everything out of reset
    PRCI_RUN        = 2'd2,
    // System domain held again after soft or debug reset
    PRCI_SYS_HOLD   = 2'd3
  } prci_state_e;

  // STATUS register contents, bit 0 is calib_done
  typedef struct packed {
    prci_state_e  state;
    logic         sys_nrst;
    logic         dbg_nrst;
    logic         ddr_nrst;
    logic         ddr_calib_done;
  } prci_status_t;

endpackage

// ==== include/soc_macros.svh ====
// Address map and register offsets of the peripheral subsystem
// GPIO width and reset hold length
// Slave select field sits in address bits 11:8

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// APB address width on the host port
`define SOC_APB_ADDR_W 12

// Low address bits that form the register offset inside a slave
`define SOC_REG_OFFS_W 8

// Slave windows, 256 bytes each
`define SOC_PRCI_BASE 12'h000
`define SOC_GPIO_BASE 12'h100

// PRCI registers
`define PRCI_REG_STATUS  8'h00
`define PRCI_REG_SOFTRST 8'h04

// GPIO registers
`define GPIO_REG_DIR 8'h00
`define GPIO_REG_OUT 8'h04
`define GPIO_REG_IN  8'h08

// Number of GPIO pins
`define SOC_GPIO_W 12

// Cycles spent in each reset hold phase
`define PRCI_RST_HOLD 16

`endif
